// ==== mirror_pkg.sv ====
package mirror_pkg;

	// --------------------------------------------------
	// Capture match
	// --------------------------------------------------
	localparam logic [19:0] WATCH_ADDR = 20'h37760;  // Low address bits of the watched register
	localparam int WATCH_BAR = 2;

	// --------------------------------------------------
	// Frame geometry
	// --------------------------------------------------
	localparam int FRAME_LEN = 60;   // Minimum Ethernet frame without FCS
	localparam int GAP_WORDS = 12;
	localparam int INDEX_W = 7;      // Wide enough for frame plus gap

	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_AW = $clog2(QUEUE_DEPTH);

	// Fixed header fields
	localparam logic [31:0] MAGIC_CODE = 32'ha1110000;
	localparam logic [7:0] IP_TTL = 8'd64;
	localparam logic [15:0] IP_ID = 16'd1;
	localparam logic [15:0] UDP_PORT = 16'd3422;
	localparam logic [15:0] IP_LEN = 16'(FRAME_LEN - 14);   // Frame minus Ethernet header
	localparam logic [15:0] UDP_LEN = 16'(FRAME_LEN - 34);  // Frame minus Ethernet and IPv4

	// --------------------------------------------------
	// Shared types
	// --------------------------------------------------
	// One captured memory write
	typedef struct packed {
		logic [47:2] addr;
		logic [31:0] data;
	} mirror_event_t;

	// PHY transmit FIFO word
	typedef struct packed {
		logic active;    // High while the frame is on the wire
		logic [7:0] data;
	} phy_word_t;

	// Interface settings
	typedef struct packed {
		logic [47:0] src_mac;
		logic [47:0] dst_mac;
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
	} net_cfg_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		SEND,
		GAP
	} seq_state_t;

endpackage

// ==== tlp_parser.sv ====
`default_nettype none
module tlp_parser import mirror_pkg::*; (
	input logic pcie_clk,
	input logic sys_rst,
	input logic rx_st,
	input logic rx_end,
	input logic [15:0] rx_data,
	input logic [6:0] rx_bar_hit,
	output logic push,
	output mirror_event_t evt,
	input logic full,
	output logic [7:0] drop_count
);

typedef enum logic [3:0] {
	P_IDLE,
	P_HEAD1,
	P_HEAD2,
	P_HEAD3,
	P_ADDR64,
	P_ADDR48,
	P_ADDR32,
	P_ADDR16,
	P_DATA0,
	P_DATA1
} parse_state_t;

parse_state_t state;
logic is_64bit;
logic [9:0] tlp_length;
logic [47:2] tlp_addr;
logic [31:0] tlp_data;
logic start;

// Memory write with data that hits the watched BAR
assign start = rx_st && rx_bar_hit[WATCH_BAR] && rx_data[14];
assign evt = '{addr: tlp_addr, data: tlp_data};

// --------------------------------------------------
// Header walk
// --------------------------------------------------
always_ff @(posedge pcie_clk) begin
	if (sys_rst) begin
		state <= P_IDLE;
		push <= 1'b0;
		drop_count <= 8'h00;
	end else begin
		push <= 1'b0;
		case (state)
		P_IDLE: if (start) state <= P_HEAD1;
		P_HEAD1: state <= rx_end ? P_IDLE : P_HEAD2;
		P_HEAD2: state <= rx_end ? P_IDLE : P_HEAD3;
		P_HEAD3: begin
			if (rx_end)
				state <= P_IDLE;
			else
				state <= is_64bit ? P_ADDR64 : P_ADDR32;
		end
		P_ADDR64: state <= rx_end ? P_IDLE : P_ADDR48;   // Bits 63:48 not kept
		P_ADDR48: state <= rx_end ? P_IDLE : P_ADDR32;
		P_ADDR32: state <= rx_end ? P_IDLE : P_ADDR16;
		P_ADDR16: begin
			if (rx_end || {tlp_addr[19:16], rx_data[15:2], 2'b00} != WATCH_ADDR)
				state <= P_IDLE;
			else
				state <= P_DATA0;
		end
		P_DATA0: state <= rx_end ? P_IDLE : P_DATA1;
		P_DATA1: begin
			state <= P_IDLE;
			// Only single dword writes are mirrored
			if (tlp_length == 10'd1) begin
				if (full) begin
					if (drop_count != 8'hff)
						drop_count <= drop_count + 8'd1;  // Saturates
				end else begin
					push <= 1'b1;
				end
			end
		end
		default: state <= P_IDLE;
		endcase
	end
end

// Field capture
always_ff @(posedge pcie_clk) begin
	case (state)
	P_IDLE: if (rx_st) is_64bit <= rx_data[13];
	P_HEAD1: tlp_length <= rx_data[9:0];
	P_HEAD3: tlp_addr[47:32] <= 16'h0;  // 32-bit header has no upper part
	P_ADDR48: tlp_addr[47:32] <= rx_data;
	P_ADDR32: tlp_addr[31:16] <= rx_data;
	P_ADDR16: tlp_addr[15:2] <= rx_data[15:2];
	P_DATA0: tlp_data[31:16] <= rx_data;
	P_DATA1: tlp_data[15:0] <= rx_data;
	default: ;
	endcase
end

// Full only falls between the decision and the push, since this is the only writer
a_no_push_full: assert property (@(posedge pcie_clk) disable iff (sys_rst)
	push |-> !full);

endmodule
`default_nettype wire

// ==== event_queue.sv ====
`default_nettype none
module event_queue import mirror_pkg::*; (
	input logic pcie_clk,
	input logic sys_rst,
	input logic push,
	input mirror_event_t din,
	output logic full,
	input logic pop,
	output mirror_event_t dout,
	output logic empty
);

mirror_event_t mem [QUEUE_DEPTH];
logic [QUEUE_AW-1:0] wr_ptr;
logic [QUEUE_AW-1:0] rd_ptr;
logic [QUEUE_AW:0] count;
logic wr_en;
logic rd_en;

assign full = int'(count) == QUEUE_DEPTH;
assign empty = count == '0;
assign wr_en = push && !full;
assign rd_en = pop && !empty;

assign dout = mem[rd_ptr];  // Head is valid whenever not empty

always_ff @(posedge pcie_clk) begin
	if (wr_en)
		mem[wr_ptr] <= din;
end

always_ff @(posedge pcie_clk) begin
	if (sys_rst) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
	end else begin
		if (wr_en)
			wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
		if (rd_en)
			rd_ptr <= rd_ptr + 1'b1;
		case ({wr_en, rd_en})
		2'b10: count <= count + 1'b1;
		2'b01: count <= count - 1'b1;
		default: ;
		endcase
	end
end

a_no_pop_empty: assert property (@(posedge pcie_clk) disable iff (sys_rst)
	pop |-> !empty);

endmodule
`default_nettype wire

// ==== frame_sequencer.sv ====
`default_nettype none
module frame_sequencer import mirror_pkg::*; (
	input logic pcie_clk,
	input logic sys_rst,
	input logic empty,
	output logic pop,
	output logic load,
	output logic step,
	output logic clear,
	input logic frame_last,
	input logic gap_last,
	input logic phy_full,
	output logic phy_wr_en,
	output logic frame_active
);

seq_state_t state;

// --------------------------------------------------
// Handshake outputs
// --------------------------------------------------
assign load = state == LOAD;   // Builder latches the head
assign pop = state == LOAD;    // Head retires in the same cycle
assign clear = state == LOAD;  // Timer starts from byte zero

// Back-pressure freezes both the state and the timer
assign phy_wr_en = (state == SEND || state == GAP) && !phy_full;
assign step = phy_wr_en;
assign frame_active = state == SEND;

always_ff @(posedge pcie_clk) begin
	if (sys_rst) begin
		state <= IDLE;
	end else begin
		case (state)
		IDLE: begin
			if (!empty)
				state <= LOAD;
		end
		LOAD: state <= SEND;  // Checksum settles here
		SEND: begin
			if (phy_wr_en && frame_last)
				state <= GAP;
		end
		GAP: begin
			if (phy_wr_en && gap_last)
				state <= IDLE;
		end
		default: state <= IDLE;
		endcase
	end
end

a_no_wr_full: assert property (@(posedge pcie_clk) disable iff (sys_rst)
	phy_wr_en |-> !phy_full);

endmodule
`default_nettype wire

// ==== byte_timer.sv ====
`default_nettype none
module byte_timer import mirror_pkg::*; (
	input logic pcie_clk,
	input logic sys_rst,
	input logic step,
	input logic clear,
	output logic [INDEX_W-1:0] index,
	output logic frame_last,
	output logic gap_last
);

// Frame bytes are 0 to FRAME_LEN-1, gap words follow on the same count
assign frame_last = index == INDEX_W'(FRAME_LEN - 1);
assign gap_last = index == INDEX_W'(FRAME_LEN + GAP_WORDS - 1);

always_ff @(posedge pcie_clk) begin
	if (sys_rst || clear) begin
		index <= '0;
	end else if (step) begin
		if (gap_last)
			index <= '0;  // Wrap after the last gap word
		else
			index <= index + 1'b1;
	end
end

endmodule
`default_nettype wire

// ==== frame_builder.sv ====
`default_nettype none
module frame_builder import mirror_pkg::*; (
	input logic pcie_clk,
	input logic sys_rst,
	input logic load,
	input mirror_event_t evt,
	input net_cfg_t cfg,
	input logic [INDEX_W-1:0] index,
	input logic frame_active,
	output phy_word_t phy_din
);

mirror_event_t ev_q;
logic [15:0] ip_csum;
logic [19:0] sum_raw;
logic [16:0] sum_fold;
logic [15:0] sum_end;
logic [FRAME_LEN-1:0][7:0] frame;
logic [INDEX_W-1:0] pos;
logic [7:0] frame_byte;

// --------------------------------------------------
// IPv4 header checksum
// --------------------------------------------------
// Flags and fragment offset are zero and drop out of the sum
assign sum_raw = 20'h04500 + IP_LEN + IP_ID + {IP_TTL, 8'h11}
	+ cfg.src_ip[31:16] + cfg.src_ip[15:0]
	+ cfg.dst_ip[31:16] + cfg.dst_ip[15:0];
assign sum_fold = sum_raw[15:0] + sum_raw[19:16];
assign sum_end = sum_fold[15:0] + sum_fold[16];  // End-around carry

always_ff @(posedge pcie_clk) begin
	if (sys_rst)
		ip_csum <= 16'h0;
	else if (load)
		ip_csum <= ~sum_end;
end

always_ff @(posedge pcie_clk) begin
	if (load)
		ev_q <= evt;
end

// --------------------------------------------------
// Frame image, first byte in the top slot
// --------------------------------------------------
assign frame = {
	cfg.dst_mac, cfg.src_mac, 16'h0800,                 // Ethernet
	8'h45, 8'h00, IP_LEN, IP_ID, 16'h0000,
	IP_TTL, 8'h11, ip_csum, cfg.src_ip, cfg.dst_ip,     // IPv4, protocol UDP
	UDP_PORT, UDP_PORT, UDP_LEN, 16'h0000,              // UDP, no checksum
	MAGIC_CODE, 8'hc1, 8'hff,
	ev_q.addr[39:2], 2'b00,                             // Captured address
	ev_q.data,
	24'h0                                               // Pad
};

assign pos = INDEX_W'(FRAME_LEN - 1) - index;
assign frame_byte = (int'(index) < FRAME_LEN) ? frame[pos] : 8'h00;

// Gap words carry a zero byte
assign phy_din = '{active: frame_active, data: frame_active ? frame_byte : 8'h00};

endmodule
`default_nettype wire

// ==== mirror_top.sv ====
`default_nettype none
module mirror_top import mirror_pkg::*; (
	input logic pcie_clk,
	input logic sys_rst,
	// Receive stream
	input logic rx_st,
	input logic rx_end,
	input logic [15:0] rx_data,
	input logic [6:0] rx_bar_hit,
	input net_cfg_t cfg,
	// PHY transmit FIFO
	output phy_word_t phy_din,
	input logic phy_full,
	output logic phy_wr_en,
	output logic [7:0] drop_count
);

mirror_event_t cap_event;
mirror_event_t head_event;
logic push;
logic full;
logic pop;
logic empty;
logic load;
logic step;
logic clear;
logic frame_last;
logic gap_last;
logic frame_active;
logic [INDEX_W-1:0] index;

tlp_parser u_parser (
	.pcie_clk(pcie_clk),
	.sys_rst(sys_rst),
	.rx_st(rx_st),
	.rx_end(rx_end),
	.rx_data(rx_data),
	.rx_bar_hit(rx_bar_hit),
	.push(push),
	.evt(cap_event),
	.full(full),
	.drop_count(drop_count)
);

event_queue u_queue (
	.pcie_clk(pcie_clk),
	.sys_rst(sys_rst),
	.push(push),
	.din(cap_event),
	.full(full),
	.pop(pop),
	.dout(head_event),
	.empty(empty)
);

frame_sequencer u_seq (
	.pcie_clk(pcie_clk),
	.sys_rst(sys_rst),
	.empty(empty),
	.pop(pop),
	.load(load),
	.step(step),
	.clear(clear),
	.frame_last(frame_last),
	.gap_last(gap_last),
	.phy_full(phy_full),
	.phy_wr_en(phy_wr_en),
	.frame_active(frame_active)
);

byte_timer u_timer (
	.pcie_clk(pcie_clk),
	.sys_rst(sys_rst),
	.step(step),
	.clear(clear),
	.index(index),
	.frame_last(frame_last),
	.gap_last(gap_last)
);

frame_builder u_builder (
	.pcie_clk(pcie_clk),
	.sys_rst(sys_rst),
	.load(load),
	.evt(head_event),
	.cfg(cfg),
	.index(index),
	.frame_active(frame_active),
	.phy_din(phy_din)
);

endmodule
`default_nettype wire

// ==== tb_mirror.sv ====
module tb_mirror import mirror_pkg::*; ();

localparam int DRAIN_LIMIT = 3000;   // Cycles allowed for queued frames to leave
localparam int QUIET_CYCLES = 400;

logic pcie_clk;
logic sys_rst;
logic rx_st;
logic rx_end;
logic [15:0] rx_data;
logic [6:0] rx_bar_hit;
net_cfg_t cfg;
phy_word_t phy_din;
logic phy_full;
logic phy_wr_en;
logic [7:0] drop_count;

logic hold_full;          // Forces phy_full high during a burst
phy_word_t exp_q [$];     // Words still due on the PHY port
int words_checked;
int error_count;

mirror_top uut (
	.pcie_clk(pcie_clk),
	.sys_rst(sys_rst),
	.rx_st(rx_st),
	.rx_end(rx_end),
	.rx_data(rx_data),
	.rx_bar_hit(rx_bar_hit),
	.cfg(cfg),
	.phy_din(phy_din),
	.phy_full(phy_full),
	.phy_wr_en(phy_wr_en),
	.drop_count(drop_count)
);

initial begin
	pcie_clk = 1'b0;
	forever #50 pcie_clk = ~pcie_clk;
end

// --------------------------------------------------
// Reporting and checks
// --------------------------------------------------
task automatic stop_run();
	error_count++;
	$display("Regression failed");
	$fatal(1, "stopped at first error");
endtask

task automatic abort_run(string why);
	$display("ERROR at time %0t: %s", $time, why);
	stop_run();
endtask

task automatic check_word(string name, phy_word_t got, phy_word_t want);
	if (got !== want) begin
		$display("FAIL time=%0t signal=%s got=%h expected=%h (word %0d)",
			$time, name, got, want, words_checked);
		stop_run();
	end
endtask

task automatic check_count(string name, logic [7:0] got, logic [7:0] want);
	if (got !== want) begin
		$display("FAIL time=%0t signal=%s got=%0d expected=%0d", $time, name, got, want);
		stop_run();
	end
endtask

// --------------------------------------------------
// Expected frame model
// --------------------------------------------------
function automatic logic [15:0] ip_checksum(logic [31:0] src, logic [31:0] dst);
	logic [31:0] sum;
	sum = 32'h4500 + IP_LEN + IP_ID + {IP_TTL, 8'h11};  // Checksum field counts as zero
	sum += src[31:16] + src[15:0] + dst[31:16] + dst[15:0];
	while (sum[31:16] != 16'h0)
		sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
	return ~sum[15:0];
endfunction

task automatic push_bytes(logic [63:0] value, int nbytes);
	int i;
	for (i = nbytes - 1; i >= 0; i--)
		exp_q.push_back('{active: 1'b1, data: value[8*i +: 8]});  // Most significant first
endtask

task automatic queue_frame(logic [47:0] addr, logic [31:0] data);
	push_bytes(cfg.dst_mac, 6);
	push_bytes(cfg.src_mac, 6);
	push_bytes(16'h0800, 2);
	push_bytes(16'h4500, 2);
	push_bytes(IP_LEN, 2);
	push_bytes(IP_ID, 2);
	push_bytes(16'h0000, 2);   // Flags, fragment offset
	push_bytes({IP_TTL, 8'h11}, 2);
	push_bytes(ip_checksum(cfg.src_ip, cfg.dst_ip), 2);
	push_bytes(cfg.src_ip, 4);
	push_bytes(cfg.dst_ip, 4);
	push_bytes({UDP_PORT, UDP_PORT}, 4);
	push_bytes({UDP_LEN, 16'h0000}, 4);
	push_bytes(MAGIC_CODE, 4);
	push_bytes(16'hc1ff, 2);
	push_bytes({addr[39:2], 2'b00}, 5);
	push_bytes(data, 4);
	push_bytes(24'h0, 3);      // Pad to minimum length
	repeat (GAP_WORDS)
		exp_q.push_back('{active: 1'b0, data: 8'h00});
endtask

// --------------------------------------------------
// Receive stream driver
// --------------------------------------------------
task automatic send_tlp(int kind, logic [6:0] bar, logic [47:0] addr, logic [31:0] data);
	logic [15:0] words [$];
	logic is_wr;
	logic is_64;
	int i;
	is_wr = kind != 2;
	is_64 = kind == 1;
	words.push_back({1'b0, is_wr, is_64, 13'h0000});
	words.push_back(16'h0001);   // One dword
	words.push_back(16'h0100);   // Requester
	words.push_back(16'h000f);   // Tag and byte enables
	if (is_64) begin
		words.push_back(16'h0000);
		words.push_back(addr[47:32]);
	end
	words.push_back(addr[31:16]);
	words.push_back({addr[15:2], 2'b00});
	if (is_wr) begin
		words.push_back(data[31:16]);
		words.push_back(data[15:0]);
	end
	if (kind == 3)
		void'(words.pop_back());  // Ends on the first data word
	for (i = 0; i < words.size(); i++) begin
		@(posedge pcie_clk);
		rx_st <= i == 0;
		rx_end <= i == words.size() - 1;
		rx_data <= words[i];
		rx_bar_hit <= bar;
	end
endtask

task automatic idle_bus();
	@(posedge pcie_clk);
	rx_st <= 1'b0;
	rx_end <= 1'b0;
	rx_data <= 16'h0;
	rx_bar_hit <= 7'h0;
endtask

task automatic wait_drain(int limit);
	int n;
	seq_state_t st;
	n = 0;
	while (exp_q.size() != 0 && n < limit) begin
		@(posedge pcie_clk);
		n++;
	end
	if (exp_q.size() != 0) begin
		st = uut.u_seq.state;
		abort_run($sformatf("frames did not drain in %0d cycles, %0d words due, sequencer in %s",
			limit, exp_q.size(), st.name()));
	end
endtask

task automatic finish_burst(int drops);
	idle_bus();
	hold_full <= 1'b0;
	wait_drain(DRAIN_LIMIT);
	check_count("drop_count", drop_count, 8'(drops));
endtask

// PHY FIFO model
initial begin : phy_model
	void'($urandom(32'h24b3_53f3));
	forever begin
		@(posedge pcie_clk);
		phy_full <= hold_full ? 1'b1 : ($urandom % 4 == 0);
	end
end

// Outputs are sampled mid-cycle
always @(negedge pcie_clk) begin : watch_phy
	phy_word_t want;
	if (!sys_rst && phy_wr_en) begin
		if (phy_full)
			abort_run("PHY write issued while phy_full was high");
		else if (exp_q.size() == 0)
			abort_run("PHY write appeared with no frame expected");
		else begin
			want = exp_q.pop_front();
			check_word("phy_din", phy_din, want);
			words_checked++;
		end
	end
end

// --------------------------------------------------
// Pattern walk
// --------------------------------------------------
initial begin
	int fd;
	string line;
	int kind;
	int want;
	int exp_drops;
	int n_lines;
	int i;
	bit in_burst;
	logic [7:0] bar;
	logic [47:0] addr;
	logic [31:0] data;
	exp_drops = 0;
	n_lines = 0;
	in_burst = 1'b0;
	error_count = 0;
	words_checked = 0;
	hold_full = 1'b0;
	sys_rst = 1'b1;
	rx_st = 1'b0;
	rx_end = 1'b0;
	rx_data = 16'h0;
	rx_bar_hit = 7'h0;
	phy_full = 1'b0;
	cfg = '{src_mac: 48'h020a_0b0c_0d0e, dst_mac: 48'h001b_213c_4d5e,
		src_ip: 32'hc0a8_0a02, dst_ip: 32'hc0a8_0a01};
	repeat (5) @(posedge pcie_clk);
	sys_rst <= 1'b0;
	@(posedge pcie_clk);
	check_count("drop_count", drop_count, 8'h00);
	fd = $fopen("mirror_patterns.txt", "r");
	if (fd == 0)
		abort_run("could not open mirror_patterns.txt");
	while (!$feof(fd)) begin
		line = "";
		if ($fgets(line, fd) == 0)
			continue;
		if (line.len() < 9 || line.substr(0, 0) == "#")
			continue;
		if ($sscanf(line, "%d %h %h %h %d", kind, bar, addr, data, want) != 5)
			abort_run({"malformed pattern line: ", line});
		if (kind == 4 && !in_burst) begin
			hold_full <= 1'b1;   // Stall the PHY so the queue fills
			in_burst = 1'b1;
		end else if (kind != 4 && in_burst) begin
			finish_burst(exp_drops);
			in_burst = 1'b0;
		end
		if (want == 1)
			queue_frame(kind == 1 ? addr : {16'h0, addr[31:0]}, data);
		else if (want == 2)
			exp_drops++;   // Matching write that meets a full queue
		send_tlp(kind == 4 ? 0 : kind, bar[6:0], addr, data);
		if (!in_burst) begin
			idle_bus();
			wait_drain(DRAIN_LIMIT);
		end
		n_lines++;
	end
	$fclose(fd);
	if (in_burst)
		finish_burst(exp_drops);
	check_count("drop_count", drop_count, 8'(exp_drops));
	// Any stray frame shows up in the monitor
	for (i = 0; i < QUIET_CYCLES; i++)
		@(posedge pcie_clk);
	$display("%0d patterns, %0d PHY words checked", n_lines, words_checked);
	if (error_count == 0)
		$display("Regression passed");
	else
		$display("Regression failed");
	$finish;
end

endmodule

// ==== mirror_patterns.txt ====
# kind: 0 write 32-bit header, 1 write 64-bit header, 2 read, 3 early end, 4 burst write
# kind bar_hit addr48 data frame (0 none, 1 frame, 2 dropped on full queue)
0 04 000000037760 deadbeef 1
1 04 12ab5c037760 0badf00d 1
2 04 000000037760 00000000 0
0 02 000000037760 11111111 0
0 04 000000037764 22222222 0
3 04 000000037760 33333333 0
1 00 000000037760 66666666 0
1 04 800000047760 77777777 0
0 7f 000000037760 44444444 1
1 04 000000037760 55555555 1
0 04 0000a1b37760 c0ffee01 1
1 04 00ff00137760 8badf00d 1
4 04 000000037760 b0000001 1
4 04 000000037760 b0000002 1
4 04 000000037760 b0000003 1
4 04 000000037760 b0000004 1
4 04 000000037760 b0000005 1
4 04 000000037760 b0000006 2
4 04 000000037760 b0000007 2
0 04 000000037760 feedface 1

// ==== sim.f ====
mirror_pkg.sv
tlp_parser.sv
event_queue.sv
frame_sequencer.sv
byte_timer.sv
frame_builder.sv
mirror_top.sv
tb_mirror.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the PCIe write mirror testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_mirror -o tb_mirror
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_mirror > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
	echo "Simulation reported failure, see $LOG"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi
echo "Simulation finished without failure"
exit 0
